// ==== src/spi_link_pkg.sv ====
package spi_link_pkg;

  // ########################################
  // Link timing

  localparam int SYNC_STAGES = 2;   // Pin synchronizer depth

  // Cycles from rx_done until the shifter reloads, covering one
  // req/ack access and the capture of its read data
  localparam int REPLY_GAP = 3;

  // ########################################
  // Link types

  typedef struct packed {
    logic cpol;   // Idle level of mclk
    logic cpha;   // 1 = sample on trailing edge
  } spi_mode_t;

  // One sendclk cycle of link activity
  typedef struct packed {
    logic frame_start;   // Select just went active
    logic frame_end;     // Select just went inactive
    logic sample;        // Capture mosi now
    logic shift;         // Present next miso bit now
    logic mosi_bit;      // Synchronized mosi
  } spi_event_t;

endpackage

// ==== src/reg_access_pkg.sv ====
package reg_access_pkg;

  typedef logic [7:0] reg_data_t;

  // ########################################
  // Command byte layout

  typedef struct packed {
    logic       write;   // 1 = write, 0 = read
    logic [6:0] addr;
  } reg_cmd_t;

  // ########################################
  // Access channel, valid while req is high

  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    reg_data_t  wdata;   // Ignored on reads
  } reg_req_t;

endpackage

// ==== src/spi_edge_decode.sv ====
module spi_edge_decode import spi_link_pkg::*; (
  input  logic       sendclk,
  input  logic       rst,
  input  spi_mode_t  mode,
  input  logic       mclk,
  input  logic       select,
  input  logic       mosi,
  output spi_event_t link_evt
);

  typedef struct packed {
    logic mclk;
    logic select;   // Active high
    logic mosi;
  } pin_set_t;

  pin_set_t sync_q [SYNC_STAGES];
  pin_set_t pins;
  logic     mclk_q;
  logic     select_q;
  logic     rise;
  logic     fall;
  logic     leading;
  logic     trailing;

  // ########################################
  // Pin synchronizers

  always_ff @(posedge sendclk)
  begin
    if (rst)
    begin
      for (int i = 0; i < SYNC_STAGES; i++)
      begin
        sync_q[i] <= '0;
      end
    end
    else
    begin
      sync_q[0] <= '{mclk: mclk, select: select, mosi: mosi};
      for (int i = 1; i < SYNC_STAGES; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign pins = sync_q[SYNC_STAGES-1];

  // ########################################
  // Edge classification

  assign rise     = pins.mclk & ~mclk_q;
  assign fall     = ~pins.mclk & mclk_q;
  assign leading  = mode.cpol ? fall : rise;   // Away from idle level
  assign trailing = mode.cpol ? rise : fall;

  always_ff @(posedge sendclk)
  begin
    if (rst)
    begin
      mclk_q   <= 1'b0;
      select_q <= 1'b0;
      link_evt <= '0;
    end
    else
    begin
      mclk_q               <= pins.mclk;
      select_q             <= pins.select;
      link_evt.frame_start <= pins.select & ~select_q;
      link_evt.frame_end   <= ~pins.select & select_q;
      link_evt.sample      <= pins.select & (mode.cpha ? trailing : leading);
      link_evt.shift       <= pins.select & (mode.cpha ? leading : trailing);
      link_evt.mosi_bit    <= pins.mosi;
    end
  end

endmodule

// ==== src/spi_shifter.sv ====
module spi_shifter import spi_link_pkg::*; #(
  parameter int NBYTES = 1
) (
  input  logic                sendclk,
  input  logic                rst,
  input  spi_event_t          link_evt,
  input  logic [8*NBYTES-1:0] tx_word,
  output logic                miso,
  output logic [8*NBYTES-1:0] rx_word,
  output logic                rx_done,
  output logic                tx_load
);

  localparam int W     = 8 * NBYTES;
  localparam int CNT_W = $clog2(W);

  logic [W-1:0]         sr;         // Out at the top, in at the bottom
  logic [CNT_W-1:0]     bit_cnt;    // Samples taken in this word
  logic [REPLY_GAP-1:0] load_dly;
  logic                 last_bit;
  logic                 word_done;

  assign last_bit  = bit_cnt == CNT_W'(W - 1);
  assign word_done = link_evt.sample & last_bit;

  // ########################################
  // Bit counter, load requests and miso

  always_ff @(posedge sendclk)
  begin
    if (rst)
    begin
      bit_cnt  <= '0;
      rx_done  <= 1'b0;
      tx_load  <= 1'b0;
      load_dly <= '0;
      miso     <= 1'b0;
    end
    else
    begin
      rx_done  <= word_done;
      tx_load  <= link_evt.frame_start | (load_dly[REPLY_GAP-1] & ~link_evt.frame_end);
      load_dly <= {load_dly[REPLY_GAP-2:0], word_done};

      if (link_evt.frame_start || link_evt.frame_end)
      begin
        bit_cnt  <= '0;
        load_dly <= '0;
      end
      else if (link_evt.sample)
      begin
        bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
      end

      if (link_evt.frame_end)
        miso <= 1'b0;
      else if (tx_load)
        miso <= tx_word[W-1];
      else if (link_evt.shift && bit_cnt != '0)   // No advance before first sample
        miso <= sr[W-1];
    end
  end

  // ########################################
  // Shift register

  always_ff @(posedge sendclk)
  begin
    if (tx_load)
      sr <= tx_word;
    else if (link_evt.sample)
      sr <= {sr[W-2:0], link_evt.mosi_bit};

    if (word_done)
      rx_word <= {sr[W-2:0], link_evt.mosi_bit};
  end

endmodule

// ==== src/spi_cmd_result.sv ====
module spi_cmd_result import spi_link_pkg::*, reg_access_pkg::*; #(
  parameter int         NBYTES   = 1,
  parameter logic [7:0] SLAVE_ID = 8'h5A
) (
  input  logic                sendclk,
  input  logic                rst,
  input  spi_event_t          link_evt,
  input  logic [8*NBYTES-1:0] rx_word,
  input  logic                rx_done,
  input  logic                tx_load,
  input  logic                ack,
  input  reg_data_t           rdata,
  output logic [8*NBYTES-1:0] tx_word,
  output logic                req,
  output reg_req_t            req_data
);

  localparam int W = 8 * NBYTES;

  logic [1:0] byte_cnt;      // Saturates at 2
  reg_cmd_t   rx_cmd;
  reg_cmd_t   cmd_q;
  logic       access_now;
  logic       access_pend;   // Waiting for ack to drop
  reg_req_t   access_data;
  logic       read_back;

  assign rx_cmd    = reg_cmd_t'(rx_word[7:0]);   // Low byte of the word
  assign read_back = req & ack & ~req_data.write;

  // ########################################
  // Byte decode

  always_comb
  begin
    access_now  = 1'b0;
    access_data = '{write: 1'b0, addr: rx_cmd.addr, wdata: '0};
    if (rx_done && byte_cnt == 2'd0 && !rx_cmd.write)
      access_now = 1'b1;   // Read right after the command
    if (rx_done && byte_cnt == 2'd1 && cmd_q.write)
    begin
      access_now  = 1'b1;
      access_data = '{write: 1'b1, addr: cmd_q.addr, wdata: rx_word[7:0]};
    end
  end

  // ########################################
  // Byte count and req/ack

  always_ff @(posedge sendclk)
  begin
    if (rst)
    begin
      byte_cnt    <= '0;
      req         <= 1'b0;
      access_pend <= 1'b0;
    end
    else
    begin
      if (link_evt.frame_start)
        byte_cnt <= '0;
      else if (rx_done && byte_cnt != 2'd2)
        byte_cnt <= byte_cnt + 1'b1;

      if (req && ack)
        req <= 1'b0;
      else if ((access_now || access_pend) && !req && !ack)
      begin
        req         <= 1'b1;
        access_pend <= 1'b0;
      end
      else if (access_now && !req)
        access_pend <= 1'b1;
    end
  end

  // ########################################
  // Command, request payload and reply word

  always_ff @(posedge sendclk)
  begin
    if (rx_done && byte_cnt == 2'd0)
      cmd_q <= rx_cmd;

    if (access_now && !req)
      req_data <= access_data;   // Held while req is high

    if (link_evt.frame_start)
      tx_word <= W'(SLAVE_ID);
    else if (read_back)
      tx_word <= W'(rdata);
    else if (tx_load)
      tx_word <= '0;   // Default reply for later bytes
  end

endmodule

// ==== src/reg_bank.sv ====
module reg_bank import reg_access_pkg::*; #(
  parameter int ADDR_W = 3
) (
  input  logic      sendclk,
  input  logic      rst,
  input  logic      req,
  input  reg_req_t  req_data,
  output logic      ack,
  output reg_data_t rdata
);

  typedef enum logic {
    IDLE,
    ACKED
  } state_t;

  state_t            state;
  reg_data_t         regs [2**ADDR_W];
  logic [ADDR_W-1:0] addr;

  assign addr = req_data.addr[ADDR_W-1:0];   // Upper bits wrap
  assign ack  = state == ACKED;

  always_ff @(posedge sendclk)
  begin
    if (rst)
    begin
      state <= IDLE;
      for (int i = 0; i < 2**ADDR_W; i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      case (state)
        IDLE:
          if (req)
          begin
            if (req_data.write)
              regs[addr] <= req_data.wdata;
            state <= ACKED;
          end
        ACKED:
          if (!req)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge sendclk)
  begin
    if (state == IDLE && req)
      rdata <= regs[addr];
  end

endmodule

// ==== src/spi_reg_slave.sv ====
module spi_reg_slave import spi_link_pkg::*, reg_access_pkg::*; #(
  parameter int         NBYTES   = 1,
  parameter int         ADDR_W   = 3,
  parameter logic [7:0] SLAVE_ID = 8'h5A
) (
  input  logic sendclk,
  input  logic rst,
  input  logic cpol,
  input  logic cpha,
  input  logic mclk,
  input  logic select,   // Active high
  input  logic mosi,
  output logic miso
);

  spi_mode_t           mode;
  spi_event_t          link_evt;
  logic [8*NBYTES-1:0] rx_word;
  logic [8*NBYTES-1:0] tx_word;
  logic                rx_done;
  logic                tx_load;
  logic                req;
  logic                ack;
  reg_req_t            req_data;
  reg_data_t           rdata;

  assign mode = '{cpol: cpol, cpha: cpha};

  spi_edge_decode decode (
    .sendclk  (sendclk),
    .rst      (rst),
    .mode     (mode),
    .mclk     (mclk),
    .select   (select),
    .mosi     (mosi),
    .link_evt (link_evt)
  );

  spi_shifter #(.NBYTES(NBYTES)) execute (
    .sendclk  (sendclk),
    .rst      (rst),
    .link_evt (link_evt),
    .tx_word  (tx_word),
    .miso     (miso),
    .rx_word  (rx_word),
    .rx_done  (rx_done),
    .tx_load  (tx_load)
  );

  spi_cmd_result #(.NBYTES(NBYTES), .SLAVE_ID(SLAVE_ID)) result (
    .sendclk  (sendclk),
    .rst      (rst),
    .link_evt (link_evt),
    .rx_word  (rx_word),
    .rx_done  (rx_done),
    .tx_load  (tx_load),
    .ack      (ack),
    .rdata    (rdata),
    .tx_word  (tx_word),
    .req      (req),
    .req_data (req_data)
  );

  reg_bank #(.ADDR_W(ADDR_W)) bank (
    .sendclk  (sendclk),
    .rst      (rst),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rdata    (rdata)
  );

endmodule

// ==== verification/spi_reg_slave_tb.sv ====
module spi_reg_slave_tb import spi_link_pkg::*; ();

  localparam logic [7:0]  SLAVE_ID  = 8'h5A;
  localparam logic [31:0] SEED      = 32'h606ca605;
  localparam int          NREGS     = 8;
  localparam int          HALF      = 4;    // mclk half-period in sendclk cycles
  localparam int          GAP       = 12;   // Idle cycles between bytes
  localparam int          SETUP     = 8;    // Select to first mclk edge
  localparam int          DRIVE_DLY = 2;

  // Two-byte transaction length, about 160 transactions, margin of 2
  localparam int TXN_CYCLES     = SETUP + 2 * (16 * HALF + GAP) + GAP;
  localparam int TIMEOUT_CYCLES = 160 * TXN_CYCLES * 2;

  logic       sendclk = 1'b0;
  logic       rst;
  logic       mclk;
  logic       select;
  logic       mosi;
  logic       miso;
  spi_mode_t  mode;
  logic [7:0] model [NREGS];   // Expected register contents
  logic [7:0] tx_bytes [4];
  logic [7:0] rx_bytes [4];
  int         cycle_cnt = 0;

  always #10 sendclk = ~sendclk;

  spi_reg_slave #(.NBYTES(1), .ADDR_W(3), .SLAVE_ID(SLAVE_ID)) u_dut (
    .sendclk (sendclk),
    .rst     (rst),
    .cpol    (mode.cpol),
    .cpha    (mode.cpha),
    .mclk    (mclk),
    .select  (select),
    .mosi    (mosi),
    .miso    (miso)
  );

  // ########################################
  // Master model

  task automatic step(input int n);
    repeat (n) @(posedge sendclk);
    #DRIVE_DLY;
  endtask

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR at time %0t: %s expected 8'h%02h, actual 8'h%02h",
               $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic set_mode(input logic cpol, input logic cpha);
    mode = '{cpol: cpol, cpha: cpha};
    mclk = cpol;   // Idle level while select is low
    step(GAP);
  endtask

  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--)
    begin
      if (mode.cpha)
        mclk = ~mode.cpol;   // Leading edge shifts
      mosi = tx[i];
      step(HALF);
      rx[i] = miso;
      mclk = mode.cpha ? mode.cpol : ~mode.cpol;   // Sample edge
      step(HALF);
      if (!mode.cpha)
        mclk = mode.cpol;
    end
  endtask

  task automatic run_txn(input int nbytes);
    select = 1'b1;
    step(SETUP);
    for (int k = 0; k < nbytes; k++)
    begin
      spi_byte(tx_bytes[k], rx_bytes[k]);
      step(GAP);
    end
    select = 1'b0;
    step(GAP);
  endtask

  task automatic spi_write(input logic [6:0] addr, input logic [7:0] data);
    tx_bytes[0] = {1'b1, addr};
    tx_bytes[1] = data;
    run_txn(2);
    check_value($sformatf("miso id reply, write %0d", addr), SLAVE_ID, rx_bytes[0]);
    check_value($sformatf("miso byte 1, write %0d", addr), 8'h00, rx_bytes[1]);
    model[addr[2:0]] = data;   // Upper address bits wrap
  endtask

  task automatic spi_read(input logic [6:0] addr, output logic [7:0] data);
    tx_bytes[0] = {1'b0, addr};
    tx_bytes[1] = 8'($urandom);
    run_txn(2);
    check_value($sformatf("miso id reply, read %0d", addr), SLAVE_ID, rx_bytes[0]);
    data = rx_bytes[1];
  endtask

  task automatic check_regs();
    logic [7:0] data;
    for (int a = 0; a < NREGS; a++)
    begin
      spi_read(7'(a), data);
      check_value($sformatf("reg[%0d]", a), model[a], data);
    end
  endtask

  // ########################################
  // Directed tests

  task automatic test_mode(input logic cpol, input logic cpha);
    set_mode(cpol, cpha);
    for (int i = 0; i < NREGS; i++)
      spi_write(7'(i), 8'($urandom));
    check_regs();
    spi_write({4'b0000, 3'($urandom)}, 8'($urandom));   // Single overwrite
    check_regs();
  endtask

  task automatic test_addr_wrap();
    logic [2:0] a;
    logic [7:0] data;
    a = 3'($urandom);
    spi_write({4'b0001, a}, 8'($urandom));
    spi_read({4'b0000, a}, data);
    check_value("read at base after write at base+8", model[a], data);
    spi_write({4'b1011, a}, 8'($urandom));
    spi_read({4'b0001, a}, data);
    check_value("read at base+8 after write at base+88", model[a], data);
    check_regs();
  endtask

  task automatic test_extra_bytes();
    logic [2:0] a;
    a = 3'($urandom);
    tx_bytes[0] = {1'b1, 4'b0000, a};
    tx_bytes[1] = 8'($urandom);
    tx_bytes[2] = {1'b1, 4'b0000, a + 3'd1};   // Looks like a write command
    tx_bytes[3] = 8'($urandom);
    run_txn(4);
    model[a] = tx_bytes[1];
    check_value("miso id reply, long write", SLAVE_ID, rx_bytes[0]);
    for (int k = 1; k < 4; k++)
      check_value($sformatf("miso byte %0d, long write", k), 8'h00, rx_bytes[k]);
    tx_bytes[0] = {1'b0, 4'b0000, a};
    run_txn(4);
    check_value("miso id reply, long read", SLAVE_ID, rx_bytes[0]);
    check_value("miso byte 1, long read", model[a], rx_bytes[1]);
    for (int k = 2; k < 4; k++)
      check_value($sformatf("miso byte %0d, long read", k), 8'h00, rx_bytes[k]);
    check_regs();
  endtask

  task automatic test_idle_mclk();
    logic [2:0] a;
    a = 3'($urandom);
    tx_bytes[0] = {1'b1, 4'b0000, a};   // Write command left without data
    run_txn(1);
    // Stray samples here would complete the open write
    for (int i = 0; i < 16; i++)
    begin
      mclk = ~mclk;
      mosi = 1'($urandom);
      step(HALF);
    end
    check_regs();
  endtask

  task automatic test_abort();
    logic [2:0] a;
    a = 3'($urandom);
    tx_bytes[0] = {1'b1, 4'b0000, a};   // Write command, no data byte
    run_txn(1);
    check_value("miso id reply, aborted write", SLAVE_ID, rx_bytes[0]);
    tx_bytes[0] = {1'b0, 4'b0000, a};
    run_txn(1);
    check_value("miso id reply, aborted read", SLAVE_ID, rx_bytes[0]);
    check_regs();
  endtask

  // ########################################
  // Sequence and timeout

  initial
  begin
    rst    = 1'b1;
    mode   = '{cpol: 1'b0, cpha: 1'b0};
    mclk   = 1'b0;
    select = 1'b0;
    mosi   = 1'b0;
    void'($urandom(SEED));
    for (int i = 0; i < NREGS; i++)
      model[i] = 8'h00;
    repeat (3) @(posedge sendclk);
    #DRIVE_DLY;
    rst = 1'b0;
    step(GAP);
    check_regs();   // Reset values
    for (int m = 0; m < 4; m++)
      test_mode(m[1], m[0]);
    test_addr_wrap();
    test_extra_bytes();
    test_idle_mclk();
    test_abort();
    $display("Test passed");
    $finish;
  end

  always @(posedge sendclk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
    begin
      $display("Timeout: tests still running after %0d sendclk cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "Simulation timed out");
    end
  end

endmodule

// ==== spi_reg_slave.f ====
src/spi_link_pkg.sv
src/reg_access_pkg.sv
src/spi_edge_decode.sv
src/spi_shifter.sv
src/spi_cmd_result.sv
src/reg_bank.sv
src/spi_reg_slave.sv
verification/spi_reg_slave_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module spi_reg_slave_tb \
  -f spi_reg_slave.f --Mdir obj_dir > build.log 2>&1 \
  || { cat build.log; echo "Verilator build error"; exit 1; }

./obj_dir/Vspi_reg_slave_tb > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
